/* ahb_usb_pkg.sv */
package ahb_usb_pkg;

  // **************************************************
  // Bus widths and address map
  // **************************************************
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  // Region bases, decoded from the top two address bits
  localparam logic [ADDR_W-1:0] STATUS_BASE  = 8'h00;
  localparam logic [ADDR_W-1:0] MAILBOX_BASE = 8'h40;
  localparam logic [ADDR_W-1:0] TXPORT_BASE  = 8'h80;

  // Offsets inside the transmit port
  localparam logic [ADDR_W-2:0] TX_PUSH_OFS = 7'h00;
  localparam logic [ADDR_W-2:0] TX_SIZE_OFS = 7'h04;

  // **************************************************
  // Bus encodings
  // **************************************************
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'd0,
    HTRANS_BUSY   = 2'd1,
    HTRANS_NONSEQ = 2'd2,
    HTRANS_SEQ    = 2'd3
  } htrans_e;

  // Codes above WORD are illegal for this slave
  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'd0,
    HSIZE_HALF = 3'd1,
    HSIZE_WORD = 3'd2
  } hsize_e;

  // RGN_NONE stays zero so a cleared record selects nothing
  typedef enum logic [1:0] {
    RGN_NONE    = 2'd0,
    RGN_STATUS  = 2'd1,
    RGN_MAILBOX = 2'd2,
    RGN_TXPORT  = 2'd3
  } region_e;

  typedef enum logic [1:0] {
    RESP_OKAY       = 2'd0,
    RESP_ERR_FIRST  = 2'd1,
    RESP_ERR_SECOND = 2'd2
  } resp_state_e;

  // **************************************************
  // Grouped signals
  // **************************************************
  // Address-phase inputs from the master
  typedef struct packed {
    logic              hsel;
    htrans_e           htrans;
    logic [ADDR_W-1:0] haddr;
    logic [2:0]        hsize;  // raw code that may be illegal
    logic              hwrite;
  } ahb_req_t;

  // Data-phase record, one entry per accepted transfer
  typedef struct packed {
    logic              active;
    logic              write;
    region_e           region;
    logic [ADDR_W-2:0] offset;
    hsize_e            size;
    logic              err;
  } data_phase_t;

  // Inputs from the USB core
  typedef struct packed {
    logic              rx_data_ready;
    logic              rx_transfer_active;
    logic              rx_error;
    logic              tx_transfer_active;
    logic              tx_error;
    logic [6:0]        buffer_occupancy;
    logic [DATA_W-1:0] rx_data;
  } usb_status_t;

  // Transmit outputs to the USB core
  typedef struct packed {
    logic              store_tx_data;
    logic [DATA_W-1:0] tx_data;
    logic [1:0]        data_size;
    logic [6:0]        tx_packet_data_size;
  } tx_port_t;

endpackage

/* ahb_addr_stage.sv */
module ahb_addr_stage (
  input  logic                     tb_clk,
  input  logic                     rst_i,
  input  ahb_usb_pkg::ahb_req_t    ahb_req_i,
  input  logic                     hready_i,
  output ahb_usb_pkg::data_phase_t dp_o
);
  import ahb_usb_pkg::*;

  logic              xfer;
  logic              size_ok;
  logic              dir_err;
  region_e           region;
  logic [ADDR_W-1:0] base;
  logic [ADDR_W-1:0] rel_addr;
  data_phase_t       dp_d;
  data_phase_t       dp_q;

  // **************************************************
  // Address-phase decode
  // **************************************************
  // Only NONSEQ and SEQ start a data phase
  // BUSY is handled like IDLE
  assign xfer = ahb_req_i.hsel &&
                (ahb_req_i.htrans == HTRANS_NONSEQ || ahb_req_i.htrans == HTRANS_SEQ);

  // Region from the upper address bits
  always_comb begin
    if (ahb_req_i.haddr >= TXPORT_BASE) begin
      region = RGN_TXPORT;
      base   = TXPORT_BASE;
    end else if (ahb_req_i.haddr >= MAILBOX_BASE) begin
      region = RGN_MAILBOX;
      base   = MAILBOX_BASE;
    end else begin
      region = RGN_STATUS;
      base   = STATUS_BASE;
    end
  end

  assign rel_addr = ahb_req_i.haddr - base;

  // Anything wider than a word is refused
  assign size_ok = (ahb_req_i.hsize <= HSIZE_WORD);

  // Status window is read-only and transmit port is write-only
  assign dir_err = (ahb_req_i.hwrite && region == RGN_STATUS) ||
                   (!ahb_req_i.hwrite && region == RGN_TXPORT);

  // Next data-phase record
  always_comb begin
    dp_d = '0;
    if (xfer) begin
      dp_d.active = 1'b1;
      dp_d.write  = ahb_req_i.hwrite;
      dp_d.err    = dir_err || !size_ok;
      dp_d.size   = size_ok ? hsize_e'(ahb_req_i.hsize) : HSIZE_WORD;
      // Erroneous beats select no region
      if (!dp_d.err) begin
        dp_d.region = region;
        dp_d.offset = rel_addr[ADDR_W-2:0];
      end
    end
  end

  // **************************************************
  // Data-phase register
  // **************************************************
  // Held through the error stall while the master keeps its next address
  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      dp_q <= '0;
    end else if (hready_i) begin
      dp_q <= dp_d;
    end
  end

  assign dp_o = dp_q;

  // Response block stalls only on an erroneous record
  a_stall_on_err: assert property (@(posedge tb_clk) disable iff (rst_i)
    !hready_i |-> dp_q.active && dp_q.err)
    else $error("hready low without an erroneous data phase");

  // Stall lasts a single cycle
  a_stall_one_cycle: assert property (@(posedge tb_clk) disable iff (rst_i)
    !hready_i |=> hready_i)
    else $error("hready held low for more than one cycle");

endmodule

/* usb_status_regs.sv */
module usb_status_regs (
  input  logic                              tb_clk,
  input  logic                              rst_i,
  input  ahb_usb_pkg::data_phase_t          dp_i,
  input  ahb_usb_pkg::usb_status_t          usb_status_i,
  output logic [ahb_usb_pkg::DATA_W-1:0]    rdata_o,
  output logic                              get_rx_data_o
);
  import ahb_usb_pkg::*;

  // Word offsets inside the status window
  localparam logic [ADDR_W-2:0] RXDATA_OFS = 7'h00;
  localparam logic [ADDR_W-2:0] FLAGS_OFS  = 7'h04;
  localparam logic [ADDR_W-2:0] OCCUP_OFS  = 7'h08;

  logic              rd_hit;
  logic [4:0]        flags;
  logic [DATA_W-1:0] flags_word;
  logic [DATA_W-1:0] occup_word;
  logic              get_rx_q;

  // **************************************************
  // Read path
  // **************************************************
  // Region is already cleared on error beats
  assign rd_hit = dp_i.active && !dp_i.write && dp_i.region == RGN_STATUS;

  // Flag order from bit 4 down
  assign flags = {usb_status_i.rx_data_ready,
                  usb_status_i.rx_transfer_active,
                  usb_status_i.rx_error,
                  usb_status_i.tx_transfer_active,
                  usb_status_i.tx_error};

  assign flags_word = DATA_W'(flags);
  assign occup_word = DATA_W'(usb_status_i.buffer_occupancy);

  // Zero when another region is addressed
  always_comb begin
    rdata_o = '0;
    if (rd_hit) begin
      case (dp_i.offset)
        RXDATA_OFS: rdata_o = usb_status_i.rx_data;
        FLAGS_OFS:  rdata_o = flags_word;
        OCCUP_OFS:  rdata_o = occup_word;
        default:    rdata_o = '0;
      endcase
    end
  end

  // **************************************************
  // Receive strobe
  // **************************************************
  // One pulse after each rx_data read tells the core to pop
  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      get_rx_q <= 1'b0;
    end else begin
      get_rx_q <= rd_hit && (dp_i.offset == RXDATA_OFS);
    end
  end

  assign get_rx_data_o = get_rx_q;

endmodule

/* tx_mailbox_regs.sv */
module tx_mailbox_regs #(
  parameter int MAILBOX_WORDS = 16
) (
  input  logic                              tb_clk,
  input  logic                              rst_i,
  input  ahb_usb_pkg::data_phase_t          dp_i,
  input  logic [ahb_usb_pkg::DATA_W-1:0]    hwdata_i,
  output logic [ahb_usb_pkg::DATA_W-1:0]    rdata_o,
  output ahb_usb_pkg::tx_port_t             tx_port_o
);
  import ahb_usb_pkg::*;

  // Index width of at least one bit
  localparam int IDX_W = (MAILBOX_WORDS > 1) ? $clog2(MAILBOX_WORDS) : 1;

  logic [DATA_W-1:0] mem [MAILBOX_WORDS];
  logic [IDX_W-1:0]  word_idx;
  logic              mbox_rd;
  logic              mbox_wr;
  logic              push_hit;
  logic              size_hit;

  // Transmit port state
  logic              store_q;
  logic [DATA_W-1:0] tx_data_q;
  logic [1:0]        data_size_q;
  logic [6:0]        pkt_size_q;

  // **************************************************
  // Mailbox RAM
  // **************************************************
  // Word index inside the 16-word window
  // Smaller mailboxes alias
  assign word_idx = IDX_W'(dp_i.offset[5:2] % MAILBOX_WORDS);

  assign mbox_rd = dp_i.active && !dp_i.write && dp_i.region == RGN_MAILBOX;
  assign mbox_wr = dp_i.active && dp_i.write && dp_i.region == RGN_MAILBOX;

  // Whole bus word stored even for narrow writes
  always_ff @(posedge tb_clk) begin
    if (mbox_wr) begin
      mem[word_idx] <= hwdata_i;
    end
  end

  // Combinational read during the data phase
  assign rdata_o = mbox_rd ? mem[word_idx] : '0;

  // **************************************************
  // Transmit port
  // **************************************************
  assign push_hit = dp_i.active && dp_i.write && dp_i.region == RGN_TXPORT &&
                    dp_i.offset == TX_PUSH_OFS;
  assign size_hit = dp_i.active && dp_i.write && dp_i.region == RGN_TXPORT &&
                    dp_i.offset == TX_SIZE_OFS;

  // Strobe and packet size
  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      store_q    <= 1'b0;
      pkt_size_q <= '0;
    end else begin
      store_q <= push_hit;
      if (size_hit) begin
        pkt_size_q <= hwdata_i[6:0];
      end
    end
  end

  // Pushed word and its size code
  always_ff @(posedge tb_clk) begin
    if (push_hit) begin
      tx_data_q   <= hwdata_i;
      data_size_q <= 2'(dp_i.size);
    end
  end

  assign tx_port_o = '{store_tx_data:       store_q,
                       tx_data:             tx_data_q,
                       data_size:           data_size_q,
                       tx_packet_data_size: pkt_size_q};

  // Reads of the write-only port never reach this block
  a_txport_write_only: assert property (@(posedge tb_clk) disable iff (rst_i)
    dp_i.active && dp_i.region == RGN_TXPORT |-> dp_i.write)
    else $error("read record selects the transmit port");

endmodule

/* ahb_resp_mux.sv */
module ahb_resp_mux (
  input  logic                              tb_clk,
  input  logic                              rst_i,
  input  ahb_usb_pkg::data_phase_t          dp_i,
  input  logic [ahb_usb_pkg::DATA_W-1:0]    status_rdata_i,
  input  logic [ahb_usb_pkg::DATA_W-1:0]    mailbox_rdata_i,
  output logic [ahb_usb_pkg::DATA_W-1:0]    hrdata_o,
  output logic                              hready_o,
  output logic                              hresp_o
);
  import ahb_usb_pkg::*;

  resp_state_e state_q;
  resp_state_e state_cur;

  // **************************************************
  // Read data
  // **************************************************
  // Unselected regions drive zero so an OR merges them
  assign hrdata_o = status_rdata_i | mailbox_rdata_i;

  // **************************************************
  // Response sequence
  // **************************************************
  // First error cycle comes straight from the record
  // Second cycle comes from the register
  always_comb begin
    state_cur = state_q;
    if (state_q == RESP_OKAY && dp_i.active && dp_i.err) begin
      state_cur = RESP_ERR_FIRST;
    end
  end

  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      state_q <= RESP_OKAY;
    end else begin
      case (state_cur)
        RESP_ERR_FIRST:  state_q <= RESP_ERR_SECOND;
        RESP_ERR_SECOND: state_q <= RESP_OKAY;
        default:         state_q <= RESP_OKAY;
      endcase
    end
  end

  // Stall only in the first error cycle
  assign hready_o = (state_cur != RESP_ERR_FIRST);
  // ERROR in both error cycles
  assign hresp_o  = (state_cur != RESP_OKAY);

  // Erroneous record still held by the address stage in the second cycle
  a_err_held: assert property (@(posedge tb_clk) disable iff (rst_i)
    state_q == RESP_ERR_SECOND |-> dp_i.active && dp_i.err)
    else $error("erroneous record released before the second error cycle");

endmodule

/* ahb_usb_slave.sv */
module ahb_usb_slave #(
  parameter int MAILBOX_WORDS = 16
) (
  input  logic                              tb_clk,
  input  logic                              rst_i,
  input  ahb_usb_pkg::ahb_req_t             ahb_req_i,
  input  logic [ahb_usb_pkg::DATA_W-1:0]    hwdata_i,
  input  ahb_usb_pkg::usb_status_t          usb_status_i,
  output logic [ahb_usb_pkg::DATA_W-1:0]    hrdata_o,
  output logic                              hready_o,
  output logic                              hresp_o,
  output logic                              get_rx_data_o,
  output ahb_usb_pkg::tx_port_t             tx_port_o
);
  import ahb_usb_pkg::*;

  // Shared data-phase record
  data_phase_t       dp;
  // Per-region read vectors
  logic [DATA_W-1:0] status_rdata;
  logic [DATA_W-1:0] mailbox_rdata;

  // **************************************************
  // Address stage
  // **************************************************
  // Single slave so hready_o doubles as bus HREADY
  ahb_addr_stage ahb_addr_stage_i (
    .tb_clk    (tb_clk),
    .rst_i     (rst_i),
    .ahb_req_i (ahb_req_i),
    .hready_i  (hready_o),
    .dp_o      (dp)
  );

  // **************************************************
  // Register regions
  // **************************************************
  usb_status_regs usb_status_regs_i (
    .tb_clk        (tb_clk),
    .rst_i         (rst_i),
    .dp_i          (dp),
    .usb_status_i  (usb_status_i),
    .rdata_o       (status_rdata),
    .get_rx_data_o (get_rx_data_o)
  );

  tx_mailbox_regs #(
    .MAILBOX_WORDS (MAILBOX_WORDS)
  ) tx_mailbox_regs_i (
    .tb_clk    (tb_clk),
    .rst_i     (rst_i),
    .dp_i      (dp),
    .hwdata_i  (hwdata_i),
    .rdata_o   (mailbox_rdata),
    .tx_port_o (tx_port_o)
  );

  // Response combiner
  ahb_resp_mux ahb_resp_mux_i (
    .tb_clk          (tb_clk),
    .rst_i           (rst_i),
    .dp_i            (dp),
    .status_rdata_i  (status_rdata),
    .mailbox_rdata_i (mailbox_rdata),
    .hrdata_o        (hrdata_o),
    .hready_o        (hready_o),
    .hresp_o         (hresp_o)
  );

endmodule

/* tb_ahb_usb_slave.sv */
module tb_ahb_usb_slave;
  timeunit 1ns;
  timeprecision 100ps;
  import ahb_usb_pkg::*;

  localparam int CLK_HALF   = 20;
  localparam int RST_CYCLES = 8;
  // Limit far above the roughly 150 cycles all tests need
  localparam int CYCLE_LIMIT = 2000;
  localparam logic [31:0] SEED = 32'h37bc_a147;

  // One queued bus transfer
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [2:0]        size;
    logic              seq;
    logic [DATA_W-1:0] wdata;
  } xfer_t;

  logic              tb_clk;
  logic              rst_i;
  ahb_req_t          req;
  logic [DATA_W-1:0] hwdata;
  usb_status_t       usb_status;
  logic [DATA_W-1:0] hrdata;
  logic              hready;
  logic              hresp;
  logic              get_rx_data;
  tx_port_t          tx_port;

  // Pending transfers and the one in its data phase
  xfer_t xq[$];
  logic  dp_valid;
  xfer_t dp_x;
  int    dp_tag;
  int    seen_tag;
  int    pcyc;

  // Reference state
  logic [DATA_W-1:0] shadow [16];
  logic [6:0]        pkt_shadow;
  logic              rx_pulse_exp;
  logic              push_exp;
  logic [DATA_W-1:0] push_data;
  logic [1:0]        push_size;

  int          n_checks    = 0;
  int          n_errors    = 0;
  int          n_tests     = 0;
  int          test_mark   = 0;
  int          err_phases  = 0;
  int          rx_pulses   = 0;
  int          push_pulses = 0;
  int          cycles;
  int          mark;
  logic [31:0] rnd;
  usb_status_t st;
  logic [31:0] size_word;

  ahb_usb_slave #(
    .MAILBOX_WORDS (16)
  ) ahb_usb_slave_i (
    .tb_clk        (tb_clk),
    .rst_i         (rst_i),
    .ahb_req_i     (req),
    .hwdata_i      (hwdata),
    .usb_status_i  (usb_status),
    .hrdata_o      (hrdata),
    .hready_o      (hready),
    .hresp_o       (hresp),
    .get_rx_data_o (get_rx_data),
    .tx_port_o     (tx_port)
  );

  initial begin
    tb_clk = 1'b0;
    forever #(CLK_HALF) tb_clk = ~tb_clk;
  end

  // **************************************************
  // Reference model
  // **************************************************
  // Writes below 0x40, reads from 0x80 up, sizes above a word
  function automatic logic is_error_access(xfer_t x);
    return (x.write && x.addr < 8'h40) || (!x.write && x.addr >= 8'h80) ||
           (x.size > 3'd2);
  endfunction

  // Expected read data for one address
  function automatic logic [DATA_W-1:0] expected_rdata(logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] d;
    d = '0;
    if (addr >= 8'h40 && addr < 8'h80) begin
      d = shadow[addr[5:2]];
    end else if (addr == 8'h00) begin
      d = usb_status.rx_data;
    end else if (addr == 8'h04) begin
      // rx_data_ready on bit 4 down to tx_error on bit 0
      d = {27'd0, usb_status.rx_data_ready, usb_status.rx_transfer_active,
           usb_status.rx_error, usb_status.tx_transfer_active, usb_status.tx_error};
    end else if (addr == 8'h08) begin
      d = {25'd0, usb_status.buffer_occupancy};
    end
    return d;
  endfunction

  // Side effects of a completed OKAY beat
  task automatic update_reference(input xfer_t x);
    if (x.write && x.addr >= 8'h40 && x.addr < 8'h80) begin
      shadow[x.addr[5:2]] = x.wdata;
    end else if (x.write && x.addr == 8'h80) begin
      push_exp  = 1'b1;
      push_data = x.wdata;
      push_size = x.size[1:0];
    end else if (x.write && x.addr == 8'h84) begin
      pkt_shadow = x.wdata[6:0];
    end else if (!x.write && x.addr == 8'h00) begin
      rx_pulse_exp = 1'b1;
    end
  endtask

  task automatic check(input string name, input logic [DATA_W-1:0] got,
                       input logic [DATA_W-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH %s got %h expected %h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    if (n_errors == test_mark) begin
      $display("test %0d %s: ok", n_tests, name);
    end else begin
      $display("test %0d %s: %0d errors", n_tests, name, n_errors - test_mark);
    end
    test_mark = n_errors;
  endtask

  // **************************************************
  // AHB master
  // **************************************************
  task automatic add_xfer(input logic [7:0] addr, input logic write,
                          input logic [2:0] size, input logic seq);
    xfer_t x;
    x.addr  = addr;
    x.write = write;
    x.size  = size;
    x.seq   = seq;
    x.wdata = $urandom;
    xq.push_back(x);
  endtask

  // Wrap bursts stay inside a block of beats*4 bytes
  task automatic add_burst(input logic [7:0] start, input int beats, input logic wrap,
                           input logic write, input logic [2:0] size);
    logic [7:0] mask;
    logic [7:0] addr;
    int         k;
    mask = 8'(beats * 4 - 1);
    for (k = 0; k < beats; k++) begin
      if (wrap) begin
        addr = (start & ~mask) | ((start + 8'(4 * k)) & mask);
      end else begin
        addr = start + 8'(4 * k);
      end
      add_xfer(addr, write, size, k > 0);
    end
  endtask

  task automatic drive_addr(input xfer_t x);
    ahb_req_t r;
    r.hsel   = 1'b1;
    r.htrans = x.seq ? HTRANS_SEQ : HTRANS_NONSEQ;
    r.haddr  = x.addr;
    r.hsize  = x.size;
    r.hwrite = x.write;
    req <= r;
  endtask

  // Pipelined run of the whole queue
  // Next address held while hready is low
  task automatic run_queue();
    xfer_t a_x;
    logic  a_busy;
    logic  rdy;
    a_busy = 1'b0;
    @(posedge tb_clk);
    if (xq.size() > 0) begin
      a_x    = xq.pop_front();
      a_busy = 1'b1;
      drive_addr(a_x);
    end
    while (a_busy || dp_valid) begin
      @(negedge tb_clk);
      rdy = hready;
      @(posedge tb_clk);
      if (rdy) begin
        // Address phase accepted and its data phase starts
        dp_valid = a_busy;
        if (a_busy) begin
          dp_x = a_x;
          dp_tag++;
          hwdata <= a_x.wdata;
        end
        if (xq.size() > 0) begin
          a_x    = xq.pop_front();
          a_busy = 1'b1;
          drive_addr(a_x);
        end else begin
          a_busy = 1'b0;
          req <= '0;
        end
      end
    end
  endtask

  // **************************************************
  // Compare process
  // **************************************************
  // Sampled mid-cycle where all outputs have settled
  always @(negedge tb_clk) begin : compare_outputs
    logic cur_err;
    if (!rst_i) begin
      // Registered outputs due from the previous beat
      check("get_rx_data_o", get_rx_data, rx_pulse_exp);
      check("store_tx_data", tx_port.store_tx_data, push_exp);
      if (push_exp) begin
        check("tx_data", tx_port.tx_data, push_data);
        check("data_size", tx_port.data_size, push_size);
      end
      check("tx_packet_data_size", tx_port.tx_packet_data_size, pkt_shadow);
      if (get_rx_data) rx_pulses++;
      if (tx_port.store_tx_data) push_pulses++;
      rx_pulse_exp = 1'b0;
      push_exp     = 1'b0;
      if (dp_valid) begin
        if (dp_tag != seen_tag) begin
          seen_tag = dp_tag;
          pcyc     = 0;
        end else begin
          pcyc++;
        end
        cur_err = is_error_access(dp_x);
        if (cur_err) begin
          // Stall in the first error cycle only
          check("hready_o", hready, (pcyc == 0) ? 32'd0 : 32'd1);
          check("hresp_o", hresp, 32'd1);
          if (hready) err_phases++;
        end else begin
          check("hready_o", hready, 32'd1);
          check("hresp_o", hresp, 32'd0);
          if (!dp_x.write) check("hrdata_o", hrdata, expected_rdata(dp_x.addr));
          if (hready) update_reference(dp_x);
        end
      end else begin
        check("hready_o", hready, 32'd1);
        check("hresp_o", hresp, 32'd0);
      end
    end
  end

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge tb_clk);
      cycles++;
    end
    $display("timeout: tests did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("STATUS: FAIL");
    $finish;
  end

  // **************************************************
  // Tests
  // **************************************************
  initial begin
    void'($urandom(SEED));
    rst_i      <= 1'b1;
    req        <= '0;
    hwdata     <= '0;
    usb_status <= '0;
    dp_valid     = 1'b0;
    dp_tag       = 0;
    seen_tag     = 0;
    pcyc         = 0;
    pkt_shadow   = '0;
    rx_pulse_exp = 1'b0;
    push_exp     = 1'b0;
    repeat (RST_CYCLES) @(posedge tb_clk);
    rst_i <= 1'b0;

    // Reset values
    @(negedge tb_clk);
    check("hready_o", hready, 32'd1);
    check("hresp_o", hresp, 32'd0);
    check("get_rx_data_o", get_rx_data, 32'd0);
    check("store_tx_data", tx_port.store_tx_data, 32'd0);
    check("tx_packet_data_size", tx_port.tx_packet_data_size, 32'd0);
    finish_test("reset values");

    // Write then read the same word back to back
    add_xfer(8'h4c, 1'b1, 3'd2, 1'b0);
    add_xfer(8'h4c, 1'b0, 3'd2, 1'b0);
    run_queue();
    finish_test("write then read");

    // Mailbox bursts that write all and then read all
    add_burst(8'h40, 16, 1'b0, 1'b1, 3'd2);
    add_burst(8'h70, 4, 1'b0, 1'b1, 3'd2);
    add_burst(8'h58, 8, 1'b1, 1'b1, 3'd2);
    add_burst(8'h44, 7, 1'b0, 1'b1, 3'd2);
    add_burst(8'h40, 16, 1'b0, 1'b0, 3'd2);
    add_burst(8'h70, 4, 1'b0, 1'b0, 3'd2);
    add_burst(8'h58, 8, 1'b1, 1'b0, 3'd2);
    add_burst(8'h44, 7, 1'b0, 1'b0, 3'd2);
    run_queue();
    finish_test("mailbox bursts");

    // Error responses and a read-back of the words the bad burst aimed at
    mark = err_phases;
    add_xfer(8'h20, 1'b1, 3'd2, 1'b0);
    add_xfer(8'h80, 1'b0, 3'd2, 1'b0);
    add_xfer(8'h44, 1'b0, 3'd3, 1'b0);
    add_burst(8'h60, 4, 1'b0, 1'b1, 3'd4);
    add_burst(8'h60, 4, 1'b0, 1'b0, 3'd2);
    run_queue();
    check("error_responses", err_phases - mark, 32'd7);
    finish_test("error responses");

    // Status window
    @(posedge tb_clk);
    rnd = $urandom;
    st.rx_data_ready      = rnd[4];
    st.rx_transfer_active = rnd[3];
    st.rx_error           = rnd[2];
    st.tx_transfer_active = rnd[1];
    st.tx_error           = rnd[0];
    st.buffer_occupancy   = rnd[11:5];
    st.rx_data            = $urandom;
    usb_status <= st;
    mark = rx_pulses;
    add_xfer(8'h00, 1'b0, 3'd2, 1'b0);
    add_xfer(8'h04, 1'b0, 3'd2, 1'b0);
    add_xfer(8'h08, 1'b0, 3'd2, 1'b0);
    run_queue();
    repeat (2) @(negedge tb_clk);
    check("get_rx_data_pulses", rx_pulses - mark, 32'd1);
    finish_test("status reads");

    // Transmit push with halfword size and then packet size
    mark = push_pulses;
    add_xfer(8'h80, 1'b1, 3'd1, 1'b0);
    add_xfer(8'h84, 1'b1, 3'd2, 1'b0);
    size_word = xq[$].wdata;
    run_queue();
    repeat (2) @(negedge tb_clk);
    check("store_tx_data_pulses", push_pulses - mark, 32'd1);
    check("tx_packet_data_size", tx_port.tx_packet_data_size, size_word[6:0]);
    finish_test("transmit port");

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
ahb_usb_pkg.sv
ahb_addr_stage.sv
usb_status_regs.sv
tx_mailbox_regs.sv
ahb_resp_mux.sv
ahb_usb_slave.sv
tb_ahb_usb_slave.sv

/* Makefile */
SRCS := $(shell cat vlog.f)

all: run

obj_dir/Vtb_ahb_usb_slave: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module tb_ahb_usb_slave -Mdir obj_dir

run: obj_dir/Vtb_ahb_usb_slave
	./obj_dir/Vtb_ahb_usb_slave | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
